//--- logic/macplus_pkg.sv
//----------------------------------------------------------------------
// shared widths, memory map and decode constants of the glue logic
// import into a module body, or use scoped names in port lists
//----------------------------------------------------------------------

package macplus_pkg;

	//----------------------------------------------------------------------
	// vector types
	//----------------------------------------------------------------------

	// cpu and memory data word
	typedef logic [15:0] word_t;
	// byte address from the host download channel
	typedef logic [23:0] ioctl_addr_t;
	// word address, byte address bits 21..1
	typedef logic [21:1] word_addr_t;
	// 68000 byte address
	typedef logic [23:0] cpu_addr_t;
	// word address on the sdram port
	typedef logic [24:0] sdram_addr_t;
	// download slot selected by the host menu
	typedef logic [4:0]  img_index_t;
	// one bit per floppy drive, bit 0 is the internal drive
	typedef logic [1:0]  drive_pair_t;
	// cpu model select from the menu
	typedef logic [1:0]  cpu_sel_t;
	// 68000 function code
	typedef logic [2:0]  fc_t;

	//----------------------------------------------------------------------
	// download indices
	//----------------------------------------------------------------------

	localparam img_index_t IDX_ROM     = 5'd0;
	localparam img_index_t IDX_DSK_INT = 5'd1;
	localparam img_index_t IDX_DSK_EXT = 5'd2;

	// final word count of a complete floppy image
	// 819200 bytes double sided, 409600 bytes single sided
	localparam logic [22:0] DSK_DS_WORDS = 23'd409600;
	localparam logic [22:0] DSK_SS_WORDS = 23'd204800;

	//----------------------------------------------------------------------
	// memory map
	//----------------------------------------------------------------------

	// disk images sit above the os rom, at 512k and 1M words
	localparam word_addr_t DSK_INT_BASE = 21'h080000;
	localparam word_addr_t DSK_EXT_BASE = 21'h100000;

	// bank bits placed on top of a download word address
	localparam logic [3:0] DOWNLOAD_BANK = 4'b0001;

	// address bits 23..21 of the autovectored i/o area
	localparam logic [2:0] IO_REGION = 3'b111;

	// function code of an interrupt acknowledge cycle
	localparam fc_t FC_INT_ACK = 3'b111;

	// default system reset hold, counted in 8 MHz strobes
	localparam logic [15:0] RESET_HOLD = 16'd65535;

endpackage

//--- logic/disk_image_detect.sv
//----------------------------------------------------------------------
// floppy image detection, flags per drive set when a download ends
// and cleared again when the system ejects the disk
//----------------------------------------------------------------------

module disk_image_detect (
	input  logic                     clk32,
	input  logic                     rst_n,
	input  logic                     dio_download,
	input  macplus_pkg::img_index_t  dio_index,
	input  macplus_pkg::ioctl_addr_t dio_addr,
	input  macplus_pkg::drive_pair_t disk_eject,
	output macplus_pkg::drive_pair_t disk_inserted,
	output macplus_pkg::drive_pair_t disk_sides
);
	import macplus_pkg::*;

	// previous download level, for the falling edge
	logic        dio_download_d;
	// end of a download, host has dropped the level
	logic        download_end;
	// download index matches drive 0 or drive 1
	drive_pair_t drive_match;
	// final address in words, addr counts bytes
	logic [22:0] image_words;
	// image size flags per drive
	drive_pair_t image_ds;
	drive_pair_t image_ss;

	assign download_end = dio_download_d & ~dio_download;
	assign drive_match  = {dio_index == IDX_DSK_EXT, dio_index == IDX_DSK_INT};
	assign image_words  = dio_addr[23:1];

	//----------------------------------------------------------------------
	// edge detect on the download level
	//----------------------------------------------------------------------
	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			dio_download_d <= 1'b0;
		end else begin
			dio_download_d <= dio_download;
		end
	end

	//----------------------------------------------------------------------
	// size latch, eject has priority
	//----------------------------------------------------------------------
	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			image_ds <= '0;
			image_ss <= '0;
		end else begin
			for (int d = 0; d < 2; d++) begin
				if (disk_eject[d]) begin
					image_ds[d] <= 1'b0;
					image_ss[d] <= 1'b0;
				end else if (download_end && drive_match[d]) begin
					// unknown sizes clear both flags
					image_ds[d] <= (image_words == DSK_DS_WORDS);
					image_ss[d] <= (image_words == DSK_SS_WORDS);
				end
			end
		end
	end

	// any known image counts as inserted
	assign disk_inserted = image_ds | image_ss;
	assign disk_sides    = image_ds;

endmodule

//--- logic/download_pacer.sv
//----------------------------------------------------------------------
// paces host download bytes into the download memory slot
// ioctl_wait stalls the host until the byte has been written
//----------------------------------------------------------------------

module download_pacer (
	input  logic clk32,
	input  logic rst_n,
	input  logic dio_wr,
	input  logic dio_slot,
	output logic ioctl_wait,
	output logic dio_write
);

	// slot level one cycle back
	logic dio_slot_d;
	// slot has just closed
	logic slot_end;

	assign slot_end = dio_slot_d & ~dio_slot;

	//----------------------------------------------------------------------
	// wait and write pulse
	//----------------------------------------------------------------------
	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			dio_slot_d <= 1'b0;
			ioctl_wait <= 1'b0;
			dio_write  <= 1'b0;
		end else begin
			dio_slot_d <= dio_slot;

			// new byte from the host, hold it off
			if (dio_wr) begin
				ioctl_wait <= 1'b1;
			end

			// write request only changes between slots,
			// so it stays stable for a whole slot
			if (!dio_slot) begin
				dio_write <= ioctl_wait;
			end

			// slot closed with a write in it, byte is in memory
			// release wins over a new byte on the same edge
			if (slot_end && dio_write) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

endmodule

//--- logic/reset_stretcher.sv
//----------------------------------------------------------------------
// system reset, any source reloads a hold counter on the 8 MHz strobe
// and the system leaves reset once the counter has run down to zero
//----------------------------------------------------------------------

module reset_stretcher #(
	parameter logic [15:0] hold_cycles = macplus_pkg::RESET_HOLD
) (
	input  logic                  clk32,
	input  logic                  rst_n,
	input  logic                  clk8_en_p,
	input  logic                  pll_locked,
	input  logic                  status_reset,
	input  logic                  reset_button,
	input  logic                  dio_download,
	input  macplus_pkg::img_index_t dio_index,
	input  logic                  mem_4mb,
	input  macplus_pkg::cpu_sel_t cpu_sel,
	input  logic                  cpu_reset_out_n,
	output logic                  system_reset_n
);
	import macplus_pkg::*;

	logic [15:0] rst_cnt;
	// configuration seen on the last strobe
	logic        last_mem_4mb;
	cpu_sel_t    last_cpu_sel;
	// os rom is being replaced
	logic        rom_download;
	logic        reset_req;

	assign rom_download = dio_download && (dio_index == IDX_ROM);

	// memory size or cpu change needs a cold start
	assign reset_req = !pll_locked || status_reset || reset_button || rom_download ||
		(last_mem_4mb != mem_4mb) || (last_cpu_sel != cpu_sel) || !cpu_reset_out_n;

	always_ff @(posedge clk32 or negedge rst_n) begin
		if (!rst_n) begin
			// power up starts with a full hold
			rst_cnt      <= hold_cycles;
			last_mem_4mb <= 1'b0;
			last_cpu_sel <= '0;
		end else if (clk8_en_p) begin
			last_mem_4mb <= mem_4mb;
			last_cpu_sel <= cpu_sel;
			if (reset_req) begin
				rst_cnt <= hold_cycles;
			end else if (rst_cnt != '0) begin
				rst_cnt <= rst_cnt - 16'd1;
			end
		end
	end

	assign system_reset_n = (rst_cnt == '0);

endmodule

//--- logic/cpu_bus_ack.sv
//----------------------------------------------------------------------
// 68000 bus acknowledge, DTACK for memory and VPA for autovectors
// turbo mode holds DTACK until the bus slot has come round
//----------------------------------------------------------------------

module cpu_bus_ack (
	input  logic                   clk32,
	input  logic                   cpu_reset_n,
	input  logic                   cpu_as_n,
	input  macplus_pkg::fc_t       cpu_fc,
	input  macplus_pkg::cpu_addr_t cpu_addr,
	input  logic                   cpu_slot,
	input  logic                   select_ram,
	input  logic                   select_rom,
	input  logic                   turbo,
	output logic                   cpu_dtack_n,
	output logic                   cpu_vpa_n
);
	import macplus_pkg::*;

	// strobe asserted
	logic as_active;
	// top of the map, vpa area
	logic in_io_region;
	logic int_ack;
	// cpu slot one cycle back, for the rising edge
	logic cpu_slot_d;
	logic slot_rise;
	// turbo dtack gate
	logic turbo_en;
	logic turbo_set;

	assign as_active    = ~cpu_as_n;
	assign in_io_region = (cpu_addr[23:21] == IO_REGION);
	assign int_ack      = (cpu_fc == FC_INT_ACK);
	assign slot_rise    = cpu_slot & ~cpu_slot_d;

	// open the gate at the start of a cpu slot, or at once when
	// the access goes to a peripheral and not to memory
	assign turbo_set = as_active & (slot_rise | (~select_ram & ~select_rom));

	//----------------------------------------------------------------------
	// turbo gate register
	//----------------------------------------------------------------------
	always_ff @(posedge clk32) begin
		cpu_slot_d <= cpu_slot;
		if (!cpu_reset_n || cpu_as_n) begin
			// cycle over or cpu in reset
			turbo_en <= 1'b0;
		end else if (turbo_set) begin
			turbo_en <= 1'b1;
		end
	end

	//----------------------------------------------------------------------
	// acknowledge outputs
	//----------------------------------------------------------------------

	// interrupt acks are always autovectored
	assign cpu_vpa_n = ~(int_ack | (as_active & in_io_region));

	// memory cycles, throttled by the gate in turbo mode
	assign cpu_dtack_n = ~(as_active & ~in_io_region) | (turbo & ~turbo_en);

endmodule

//--- logic/memory_port_mux.sv
//----------------------------------------------------------------------
// sdram port multiplexer between host downloads and cpu accesses
// also splits byte wide disk image data out of the read word
//----------------------------------------------------------------------

module memory_port_mux (
	input  logic                      dio_download,
	input  logic                      dio_slot,
	input  macplus_pkg::img_index_t   dio_index,
	input  macplus_pkg::ioctl_addr_t  dio_addr,
	input  logic [7:0]                dio_data,
	input  logic                      dio_write,
	input  macplus_pkg::word_addr_t   mem_word_addr,
	input  logic                      mem_addr_lsb,
	input  logic                      rom_oe_n,
	input  logic                      ram_oe_n,
	input  logic                      ram_we_n,
	input  logic                      uds_n,
	input  logic                      lds_n,
	input  macplus_pkg::word_t        cpu_wdata,
	input  macplus_pkg::drive_pair_t  disk_read_ack,
	input  macplus_pkg::word_t        mem_dout,
	output macplus_pkg::sdram_addr_t  mem_addr,
	output macplus_pkg::word_t        mem_din,
	output logic [1:0]                mem_ds,
	output logic                      mem_we,
	output logic                      mem_oe,
	output macplus_pkg::word_t        cpu_rdata
);
	import macplus_pkg::*;

	// download owns the port during its slot
	logic       download_cycle;
	// base of the image selected by the index
	word_addr_t dio_base;
	word_addr_t dio_word_addr;
	// disk byte copied into both halves
	word_t      disk_byte_word;

	assign download_cycle = dio_download & dio_slot;

	//----------------------------------------------------------------------
	// download address
	//----------------------------------------------------------------------
	always_comb begin
		case (dio_index)
			IDX_ROM:     dio_base = '0;
			IDX_DSK_INT: dio_base = DSK_INT_BASE;
			// all other indices land in the second drive area
			default:     dio_base = DSK_EXT_BASE;
		endcase
	end

	assign dio_word_addr = dio_addr[21:1] + dio_base;

	//----------------------------------------------------------------------
	// port select
	//----------------------------------------------------------------------
	always_comb begin
		if (download_cycle) begin
			mem_addr = {DOWNLOAD_BANK, dio_word_addr};
			mem_din  = {dio_data, dio_data};
			// even byte goes to the upper lane
			mem_ds   = {~dio_addr[0], dio_addr[0]};
			mem_we   = dio_write;
			mem_oe   = 1'b0;
		end else begin
			// rom sits one bank above ram
			mem_addr = {3'b000, ~rom_oe_n, mem_word_addr};
			mem_din  = cpu_wdata;
			mem_ds   = {~uds_n, ~lds_n};
			mem_we   = ~ram_we_n;
			mem_oe   = ~ram_oe_n | ~rom_oe_n;
		end
	end

	//----------------------------------------------------------------------
	// read data
	//----------------------------------------------------------------------

	// disk images are byte wide, pick the half by address bit 0
	assign disk_byte_word = mem_addr_lsb ? {mem_dout[7:0], mem_dout[7:0]} :
		{mem_dout[15:8], mem_dout[15:8]};

	// all ones while downloading keeps the screen black
	assign cpu_rdata = download_cycle ? 16'hffff :
		(|disk_read_ack) ? disk_byte_word : mem_dout;

endmodule

//--- logic/macplus_glue.sv
//----------------------------------------------------------------------
// glue top of the compact 68000 machine, downloads, floppy detect,
// memory port select, bus acknowledge and system reset
//----------------------------------------------------------------------

module macplus_glue #(
	parameter logic [15:0] hold_cycles = macplus_pkg::RESET_HOLD
) (
	input  logic                     clk32,
	input  logic                     rst_n,
	// host download channel
	input  logic                     dio_download,
	input  macplus_pkg::img_index_t  dio_index,
	input  macplus_pkg::ioctl_addr_t dio_addr,
	input  logic [7:0]               dio_data,
	input  logic                     dio_wr,
	input  logic                     dio_slot,
	output logic                     ioctl_wait,
	// floppy
	input  macplus_pkg::drive_pair_t disk_eject,
	output macplus_pkg::drive_pair_t disk_inserted,
	output macplus_pkg::drive_pair_t disk_sides,
	input  macplus_pkg::drive_pair_t disk_read_ack,
	// reset sources
	input  logic                     clk8_en_p,
	input  logic                     pll_locked,
	input  logic                     status_reset,
	input  logic                     reset_button,
	input  logic                     mem_4mb,
	input  macplus_pkg::cpu_sel_t    cpu_sel,
	input  logic                     cpu_reset_out_n,
	output logic                     system_reset_n,
	// cpu bus
	input  logic                     cpu_reset_n,
	input  logic                     cpu_as_n,
	input  macplus_pkg::fc_t         cpu_fc,
	input  macplus_pkg::cpu_addr_t   cpu_addr,
	input  logic                     cpu_slot,
	input  logic                     select_ram,
	input  logic                     select_rom,
	input  logic                     turbo,
	output logic                     cpu_dtack_n,
	output logic                     cpu_vpa_n,
	// memory port
	input  macplus_pkg::word_addr_t  mem_word_addr,
	input  logic                     mem_addr_lsb,
	input  logic                     rom_oe_n,
	input  logic                     ram_oe_n,
	input  logic                     ram_we_n,
	input  logic                     uds_n,
	input  logic                     lds_n,
	input  macplus_pkg::word_t       cpu_wdata,
	input  macplus_pkg::word_t       mem_dout,
	output macplus_pkg::sdram_addr_t mem_addr,
	output macplus_pkg::word_t       mem_din,
	output logic [1:0]               mem_ds,
	output logic                     mem_we,
	output logic                     mem_oe,
	output macplus_pkg::word_t       cpu_rdata
);

	// paced write strobe into the download slot
	logic dio_write;

	disk_image_detect disk_image_detect_i (.clk32, .rst_n, .dio_download, .dio_index,
		.dio_addr, .disk_eject, .disk_inserted, .disk_sides);

	download_pacer download_pacer_i (.clk32, .rst_n, .dio_wr, .dio_slot, .ioctl_wait,
		.dio_write);

	reset_stretcher #(.hold_cycles(hold_cycles)) reset_stretcher_i (.clk32, .rst_n,
		.clk8_en_p, .pll_locked, .status_reset, .reset_button, .dio_download, .dio_index,
		.mem_4mb, .cpu_sel, .cpu_reset_out_n, .system_reset_n);

	cpu_bus_ack cpu_bus_ack_i (.clk32, .cpu_reset_n, .cpu_as_n, .cpu_fc, .cpu_addr,
		.cpu_slot, .select_ram, .select_rom, .turbo, .cpu_dtack_n, .cpu_vpa_n);

	memory_port_mux memory_port_mux_i (.dio_download, .dio_slot, .dio_index, .dio_addr,
		.dio_data, .dio_write, .mem_word_addr, .mem_addr_lsb, .rom_oe_n, .ram_oe_n,
		.ram_we_n, .uds_n, .lds_n, .cpu_wdata, .disk_read_ack, .mem_dout, .mem_addr,
		.mem_din, .mem_ds, .mem_we, .mem_oe, .cpu_rdata);

endmodule

//--- verif/macplus_glue_properties.sv
//----------------------------------------------------------------------
// concurrent checks on download pacing and cpu bus acknowledge,
// bound into the glue top where both blocks meet
//----------------------------------------------------------------------

module macplus_glue_properties (
	input logic clk32,
	input logic rst_n,
	input logic dio_wr,
	input logic ioctl_wait,
	input logic cpu_as_n,
	input logic cpu_vpa_n,
	input logic cpu_dtack_n
);

	// a host byte stalls the host on the next cycle
	wait_after_wr: assert property (@(posedge clk32) disable iff (!rst_n)
		dio_wr |=> ioctl_wait)
		else $error("ioctl_wait did not rise one cycle after dio_wr");

	// autovector and memory acknowledge exclude each other
	vpa_dtack_excl: assert property (@(posedge clk32) disable iff (!rst_n)
		!(!cpu_vpa_n && !cpu_dtack_n))
		else $error("cpu_vpa_n and cpu_dtack_n both asserted");

	// no acknowledge without an address strobe
	dtack_idle: assert property (@(posedge clk32) disable iff (!rst_n)
		cpu_as_n |-> cpu_dtack_n)
		else $error("cpu_dtack_n asserted while cpu_as_n is high");

endmodule

bind macplus_glue macplus_glue_properties macplus_glue_properties_i (.clk32, .rst_n,
	.dio_wr, .ioctl_wait, .cpu_as_n, .cpu_vpa_n, .cpu_dtack_n);

//--- verif/tb_macplus_glue.sv
//----------------------------------------------------------------------
// random testbench of the glue top, lfsr stimulus against a cycle model
// first phase mixes everything, second phase lets the reset run down
//----------------------------------------------------------------------

module tb_macplus_glue;
	import macplus_pkg::*;

	localparam logic [15:0] HOLD = 16'd64;
	localparam int RESET_CYCLES = 16;
	localparam int MIXED_CYCLES = 3000;
	localparam int QUIET_CYCLES = 2000;
	localparam int TOTAL_CYCLES = RESET_CYCLES + MIXED_CYCLES + QUIET_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES;

	logic clk32, rst_n, dio_download, dio_wr, dio_slot, ioctl_wait;
	img_index_t dio_index;
	ioctl_addr_t dio_addr;
	logic [7:0] dio_data;
	drive_pair_t disk_eject, disk_inserted, disk_sides, disk_read_ack;
	logic clk8_en_p, pll_locked, status_reset, reset_button, mem_4mb;
	cpu_sel_t cpu_sel;
	logic cpu_reset_out_n, system_reset_n, cpu_reset_n, cpu_as_n;
	fc_t cpu_fc;
	cpu_addr_t cpu_addr;
	logic cpu_slot, select_ram, select_rom, turbo, cpu_dtack_n, cpu_vpa_n;
	word_addr_t mem_word_addr;
	logic mem_addr_lsb, rom_oe_n, ram_oe_n, ram_we_n, uds_n, lds_n;
	word_t cpu_wdata, mem_dout, mem_din, cpu_rdata;
	sdram_addr_t mem_addr;
	logic [1:0] mem_ds;
	logic mem_we, mem_oe;

	// model state, one variable per register rule
	logic m_dl_d, m_slot_d, m_wait, m_write, m_last_4mb, m_cslot_d, m_te;
	drive_pair_t m_ds, m_ss;
	logic [15:0] m_cnt;
	cpu_sel_t m_last_sel;

	logic [31:0] lfsr_state = 32'hdc56_3e79;
	int cycles = 0;
	int errors = 0;
	int seen_ds = 0;
	int seen_ss = 0;
	int seen_release = 0;
	logic allow_dl;

	macplus_glue #(.hold_cycles(HOLD)) dut_i (.*);

	initial begin
		clk32 = 1'b0;
		forever #2 clk32 = ~clk32;
	end

	// taps 32 22 2 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("error at %0t: %s dut %h expected %h", $time, name, got, exp);
			$display("Some tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	//----------------------------------------------------------------------
	// cycle model, called on each rising edge before new inputs land
	//----------------------------------------------------------------------
	task automatic update_model();
		logic next_wait;
		logic req;
		// turbo gate has no system reset
		if (!cpu_reset_n || cpu_as_n) m_te = 1'b0;
		else if ((cpu_slot && !m_cslot_d) || (!select_ram && !select_rom)) m_te = 1'b1;
		m_cslot_d = cpu_slot;
		if (!rst_n) begin
			m_dl_d = 1'b0;
			m_slot_d = 1'b0;
			m_wait = 1'b0;
			m_write = 1'b0;
			m_ds = '0;
			m_ss = '0;
			m_cnt = HOLD;
			m_last_4mb = 1'b0;
			m_last_sel = '0;
		end else begin
			for (int d = 0; d < 2; d++) begin
				if (disk_eject[d]) begin
					m_ds[d] = 1'b0;
					m_ss[d] = 1'b0;
				end else if (m_dl_d && !dio_download && dio_index == 5'(d + 1)) begin
					m_ds[d] = (dio_addr[23:1] == 23'd409600);
					m_ss[d] = (dio_addr[23:1] == 23'd204800);
				end
			end
			m_dl_d = dio_download;
			// wait is set by a byte and cleared when a written slot closes
			next_wait = m_wait | dio_wr;
			if (m_slot_d && !dio_slot && m_write) next_wait = 1'b0;
			if (!dio_slot) m_write = m_wait;
			m_wait = next_wait;
			m_slot_d = dio_slot;
			if (clk8_en_p) begin
				req = !pll_locked || status_reset || reset_button || !cpu_reset_out_n ||
					(dio_download && dio_index == 5'd0) ||
					(m_last_4mb != mem_4mb) || (m_last_sel != cpu_sel);
				if (req) m_cnt = HOLD;
				else if (m_cnt != 16'd0) m_cnt = m_cnt - 16'd1;
				m_last_4mb = mem_4mb;
				m_last_sel = cpu_sel;
			end
		end
		seen_ds += (m_ds != 2'b00) ? 1 : 0;
		seen_ss += ((m_ss & ~m_ds) != 2'b00) ? 1 : 0;
		seen_release += (m_cnt == 16'd0) ? 1 : 0;
	endtask

	//----------------------------------------------------------------------
	// stimulus, non blocking so the dut sees it after this edge
	//----------------------------------------------------------------------
	task automatic drive_inputs();
		logic [2:0] sel;
		int rare;
		fc_t fc;
		cpu_addr_t ca;
		rare = allow_dl ? 9 : 11;
		if (!allow_dl) begin
			dio_download <= 1'b0;
		end else if (take_bits(5) == 0) begin
			dio_download <= ~dio_download;
			if (!dio_download) begin
				// rom downloads are rare, they hold the system in reset
				sel = 3'(take_bits(3));
				dio_index <= (sel == 3'd0) ? 5'd0 : (sel[0] ? 5'd1 : 5'd2);
			end
		end
		case (take_bits(2))
			0: dio_addr <= 24'd819200;
			1: dio_addr <= 24'd409600;
			default: dio_addr <= 24'(take_bits(24));
		endcase
		dio_data <= 8'(take_bits(8));
		if (take_bits(2) == 0) dio_slot <= ~dio_slot;
		// host honours the wait, one byte at a time
		dio_wr <= !m_wait && !m_write && take_bits(1) == 1;
		disk_eject <= {take_bits(4) == 0, take_bits(4) == 0};
		disk_read_ack <= 2'(take_bits(2));
		clk8_en_p <= 1'(take_bits(1));
		pll_locked <= take_bits(rare) != 0;
		status_reset <= take_bits(rare) == 0;
		reset_button <= take_bits(rare) == 0;
		cpu_reset_out_n <= take_bits(rare) != 0;
		if (take_bits(rare) == 0) mem_4mb <= ~mem_4mb;
		if (take_bits(rare) == 0) cpu_sel <= 2'(take_bits(2));
		cpu_reset_n <= take_bits(6) != 0;
		cpu_as_n <= 1'(take_bits(1));
		fc = 3'(take_bits(3));
		ca = 24'(take_bits(24));
		// interrupt acks and some accesses go to the top of the map
		if (fc == FC_INT_ACK || take_bits(2) == 0) ca[23:21] = IO_REGION;
		cpu_fc <= fc;
		cpu_addr <= ca;
		if (take_bits(2) == 0) cpu_slot <= ~cpu_slot;
		select_ram <= 1'(take_bits(1));
		select_rom <= 1'(take_bits(1));
		turbo <= 1'(take_bits(1));
		mem_word_addr <= 21'(take_bits(21));
		mem_addr_lsb <= 1'(take_bits(1));
		rom_oe_n <= 1'(take_bits(1));
		ram_oe_n <= 1'(take_bits(1));
		ram_we_n <= 1'(take_bits(1));
		uds_n <= 1'(take_bits(1));
		lds_n <= 1'(take_bits(1));
		cpu_wdata <= 16'(take_bits(16));
		mem_dout <= 16'(take_bits(16));
	endtask

	//----------------------------------------------------------------------
	// output checks on the falling edge, all outputs settled
	//----------------------------------------------------------------------
	task automatic check_outputs();
		logic dl;
		word_addr_t base;
		word_addr_t waddr;
		word_t byte_word;
		dl = dio_download && dio_slot;
		base = (dio_index == 5'd0) ? 21'h0 : (dio_index == 5'd1) ? 21'h080000 : 21'h100000;
		waddr = dio_addr[21:1] + base;
		byte_word = mem_addr_lsb ? {mem_dout[7:0], mem_dout[7:0]} :
			{mem_dout[15:8], mem_dout[15:8]};
		check_value("disk_inserted", 32'(disk_inserted), 32'(m_ds | m_ss));
		check_value("disk_sides", 32'(disk_sides), 32'(m_ds));
		check_value("ioctl_wait", 32'(ioctl_wait), 32'(m_wait));
		check_value("system_reset_n", 32'(system_reset_n), 32'(m_cnt == 16'd0));
		check_value("cpu_vpa_n", 32'(cpu_vpa_n),
			32'(!(cpu_fc == 3'b111 || (!cpu_as_n && cpu_addr[23:21] == 3'b111))));
		check_value("cpu_dtack_n", 32'(cpu_dtack_n),
			32'(!(!cpu_as_n && cpu_addr[23:21] != 3'b111) || (turbo && !m_te)));
		check_value("mem_addr", 32'(mem_addr),
			dl ? 32'({4'b0001, waddr}) : 32'({3'b000, !rom_oe_n, mem_word_addr}));
		check_value("mem_din", 32'(mem_din), dl ? 32'({dio_data, dio_data}) : 32'(cpu_wdata));
		check_value("mem_ds", 32'(mem_ds),
			dl ? 32'({!dio_addr[0], dio_addr[0]}) : 32'({!uds_n, !lds_n}));
		check_value("mem_we", 32'(mem_we), dl ? 32'(m_write) : 32'(!ram_we_n));
		check_value("mem_oe", 32'(mem_oe), dl ? 32'd0 : 32'(!ram_oe_n || !rom_oe_n));
		check_value("cpu_rdata", 32'(cpu_rdata), dl ? 32'hffff :
			(disk_read_ack != 2'b00) ? 32'(byte_word) : 32'(mem_dout));
	endtask

	always @(posedge clk32) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		rst_n = 1'b0;
		{dio_download, dio_wr, dio_slot, clk8_en_p, status_reset, reset_button} = '0;
		{mem_4mb, cpu_slot, select_ram, select_rom, turbo, mem_addr_lsb} = '0;
		{pll_locked, cpu_reset_out_n, cpu_reset_n, cpu_as_n} = 4'hf;
		{rom_oe_n, ram_oe_n, ram_we_n, uds_n, lds_n} = 5'h1f;
		dio_index = '0;
		dio_addr = '0;
		dio_data = '0;
		disk_eject = '0;
		disk_read_ack = '0;
		cpu_sel = '0;
		cpu_fc = '0;
		cpu_addr = '0;
		mem_word_addr = '0;
		cpu_wdata = '0;
		mem_dout = '0;
		allow_dl = 1'b1;
		for (int cyc = 0; cyc < TOTAL_CYCLES; cyc++) begin
			@(posedge clk32);
			update_model();
			if (cyc == RESET_CYCLES - 1) rst_n <= 1'b1;
			allow_dl = (cyc < RESET_CYCLES + MIXED_CYCLES);
			if (cyc >= RESET_CYCLES) drive_inputs();
			@(negedge clk32);
			if (rst_n) check_outputs();
		end
		assert (seen_ds > 0) else begin
			$display("no double sided image was ever detected");
			errors++;
		end
		assert (seen_ss > 0) else begin
			$display("no single sided image was ever detected");
			errors++;
		end
		assert (seen_release > 0) else begin
			$display("the system never left reset");
			errors++;
		end
		if (errors == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "coverage goals missed");
		end
	end

endmodule

//--- macplus_glue.f
logic/macplus_pkg.sv
logic/disk_image_detect.sv
logic/download_pacer.sv
logic/reset_stretcher.sv
logic/cpu_bus_ack.sv
logic/memory_port_mux.sv
logic/macplus_glue.sv
verif/macplus_glue_properties.sv
verif/tb_macplus_glue.sv

//--- run.sh
#!/bin/sh
# build and run the glue testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f macplus_glue.f \
	--top-module tb_macplus_glue -o sim_macplus_glue; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_macplus_glue > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "All tests passed" sim.log; then
	exit 0
fi

echo "pass message not found in sim.log"
exit 1
